/* verilog.f */
hdl/im2col_pkg.sv
hdl/im2col_regs.sv
hdl/im2col_param_gen.sv
hdl/im2col_desc_fifo.sv
hdl/im2col_dma_loader.sv
hdl/im2col_top.sv
dv/im2col_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the im2col testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal -j 0 \
  --top-module im2col_tb -Mdir "$BUILD_DIR" -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vim2col_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG_FILE"; then
  exit 0
fi
exit 1

/* dv/im2col_tb.sv */
/*
 * Directed testbench of the im2col accelerator. Holds the APB
 * driver, a DMA bus model with random grants and channel
 * completion, the descriptor reference model and the tests.
 */
`timescale 1ns/1ns

module im2col_tb
  import im2col_pkg::*;
();

  localparam int GNT_DELAY_MAX  = 3;
  localparam int DONE_DELAY_MIN = 5;
  localparam int DONE_DELAY_MAX = 40;
  localparam int POLL_LIMIT     = 1000;
  localparam int IRQ_WAIT_LIMIT = 4000;
  localparam int QUIET_CYCLES   = 20;
  localparam logic [REG_ADDR_W-1:0] PTR_REGS [2] = '{REG_SRC_PTR, REG_DST_PTR};
  localparam logic [REG_ADDR_W-1:0] DIM_REGS [9] = '{REG_IW, REG_IH, REG_NUM_CH, REG_FW, REG_FH,
                                                    REG_STRIDE_W, REG_STRIDE_H, REG_NP_W, REG_NP_H};

  logic                  clk_i;
  logic                  rst_ni;
  logic                  psel_i, penable_i, pwrite_i;
  logic [REG_ADDR_W-1:0] paddr_i;
  word_t                 pwdata_i, prdata_o;
  logic                  pready_o, pslverr_o, dma_req_o, irq_o;
  word_t                 dma_addr_o, dma_wdata_o;
  logic                  dma_gnt_i = 1'b0;   // driven by the DMA model only
  ch_mask_t              dma_done_i = '0;

  int       errors, checks, done_events;
  logic     aborted;
  logic     irq_masked;    // set while a run has the interrupt disabled
  ch_idx_t  log_ch[$];     // one entry per granted DMA write
  word_t    log_off[$], log_data[$];
  ch_mask_t tb_busy, busy_hist;
  int       done_cnt [NUM_DMA_CH];
  int       gnt_wait;
  logic     req_prev;
  word_t    cfg_src, cfg_dst;
  dim_t     cfg_iw, cfg_ih, cfg_nc, cfg_fw, cfg_fh, cfg_sw, cfg_sh, cfg_npw, cfg_nph;
  word_t    exp_src[$], exp_dst[$];

  im2col_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_dim(input string name, input dim_t got, input dim_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got 0x%04h, expected 0x%04h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // setup cycle, then access cycle; the write lands at the access edge
  task automatic apb_write(input logic [REG_ADDR_W-1:0] addr, input word_t data, output logic err);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b1;
    paddr_i   <= addr;
    pwdata_i  <= data;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    err = pslverr_o;
    check_flag("pready_o", pready_o, 1'b1);
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic apb_read(input logic [REG_ADDR_W-1:0] addr, output word_t data, output logic err);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    paddr_i   <= addr;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    data = prdata_o;  // read data is combinational in the access cycle
    err  = pslverr_o;
    check_flag("pready_o", pready_o, 1'b1);
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input word_t data);
    logic err;
    apb_write(addr, data, err);
    check_flag($sformatf("pslverr_o write 0x%02h", addr), err, 1'b0);
  endtask

  // irq_o may never rise while the interrupt enable is clear
  always @(negedge clk_i) begin
    if (irq_masked) begin
      check_flag("irq_o with interrupt disabled", irq_o, 1'b0);
    end
  end

  // DMA bus model, logs granted writes and retires channels after a delay
  always @(posedge clk_i) begin : dma_model
    word_t    rel;
    word_t    off;
    ch_idx_t  ch;
    ch_mask_t done_nxt;
    rel      = dma_addr_o - DMA_BASE;
    ch       = ch_idx_t'(rel / DMA_CH_SIZE);
    off      = rel % DMA_CH_SIZE;
    done_nxt = '0;
    if (!rst_ni) begin
      tb_busy   = '0;
      busy_hist = '0;
      gnt_wait  = -1;
      for (int i = 0; i < NUM_DMA_CH; i++) done_cnt[i] = 0;
      dma_gnt_i <= 1'b0;
    end else begin
      if (dma_req_o && rel >= NUM_DMA_CH * DMA_CH_SIZE) begin
        errors++;
        $display("DMA write to 0x%08h lies outside the channel windows", dma_addr_o);
      end
      // the channel was picked at the pop, one edge before the first request
      if (dma_req_o && !req_prev) begin
        if (busy_hist[ch]) begin
          errors++;
          $display("descriptor was given DMA channel %0d while it was still busy", ch);
        end
        if (busy_hist == '0) check_flag("dma channel with both idle", ch, 1'b0);
      end
      busy_hist = tb_busy;
      for (int i = 0; i < NUM_DMA_CH; i++) begin
        if (dma_done_i[i]) begin
          tb_busy[i] = 1'b0;
          done_events++;
        end
      end
      if (dma_req_o && dma_gnt_i) begin
        log_ch.push_back(ch);
        log_off.push_back(off);
        log_data.push_back(dma_wdata_o);
        if (off == DMA_SIZE_D1_OFF) begin  // channel starts here
          tb_busy[ch]  = 1'b1;
          done_cnt[ch] = $urandom_range(DONE_DELAY_MAX, DONE_DELAY_MIN);
        end
        dma_gnt_i <= 1'b0;
        gnt_wait = -1;
      end else if (dma_req_o) begin
        if (gnt_wait < 0) gnt_wait = $urandom_range(GNT_DELAY_MAX, 0);
        if (gnt_wait == 0) dma_gnt_i <= 1'b1;
        else gnt_wait--;
      end
      for (int i = 0; i < NUM_DMA_CH; i++) begin
        if (done_cnt[i] > 0) begin
          done_cnt[i]--;
          if (done_cnt[i] == 0) done_nxt[i] = 1'b1;
        end
      end
    end
    dma_done_i <= done_nxt;
    req_prev = rst_ni & dma_req_o;
  end

  task automatic program_config();
    write_reg(REG_SRC_PTR, cfg_src);
    write_reg(REG_DST_PTR, cfg_dst);
    write_reg(REG_IW, word_t'(cfg_iw));
    write_reg(REG_IH, word_t'(cfg_ih));
    write_reg(REG_NUM_CH, word_t'(cfg_nc));
    write_reg(REG_FW, word_t'(cfg_fw));
    write_reg(REG_FH, word_t'(cfg_fh));
    write_reg(REG_STRIDE_W, word_t'(cfg_sw));
    write_reg(REG_STRIDE_H, word_t'(cfg_sh));
    write_reg(REG_NP_W, word_t'(cfg_npw));
    write_reg(REG_NP_H, word_t'(cfg_nph));
  endtask

  // expected source and destination pointers, in walk order
  task automatic build_expected();
    word_t k;
    exp_src.delete();
    exp_dst.delete();
    k = '0;
    for (int c = 0; c < int'(cfg_nc); c++) begin
      for (int h = 0; h < int'(cfg_fh); h++) begin
        for (int w = 0; w < int'(cfg_fw); w++) begin
          exp_src.push_back(cfg_src + (word_t'(c) * word_t'(cfg_ih) + word_t'(h))
                            * word_t'(cfg_iw) + word_t'(w));
          exp_dst.push_back(cfg_dst + k * word_t'(cfg_npw) * word_t'(cfg_nph));
          k++;
        end
      end
    end
  endtask

  task automatic check_log();
    int    n;
    word_t inc2;
    word_t exp_off [6];
    word_t exp_val [6];
    n    = exp_src.size();
    inc2 = word_t'(cfg_sh) * word_t'(cfg_iw) - (word_t'(cfg_npw) - 1) * word_t'(cfg_sw);
    exp_off = '{DMA_SRC_PTR_OFF, DMA_DST_PTR_OFF, DMA_INC_SRC_D1_OFF, DMA_INC_SRC_D2_OFF,
                DMA_SIZE_D2_OFF, DMA_SIZE_D1_OFF};
    if (log_off.size() != 6 * n) begin
      errors++;
      $display("DMA log holds %0d writes, but %0d descriptors need %0d", log_off.size(), n, 6 * n);
    end
    for (int d = 0; d < n && 6 * d + 5 < log_off.size(); d++) begin
      exp_val = '{exp_src[d], exp_dst[d], word_t'(cfg_sw), inc2, word_t'(cfg_nph),
                  word_t'(cfg_npw)};
      for (int j = 0; j < 6; j++) begin
        check_word($sformatf("dma_addr_o offset, desc %0d write %0d", d, j),
                   log_off[6 * d + j], exp_off[j]);
        check_word($sformatf("dma_wdata_o, desc %0d write %0d", d, j),
                   log_data[6 * d + j], exp_val[j]);
        if (j > 0) begin  // all six writes of a descriptor share one channel
          check_flag($sformatf("dma channel, desc %0d write %0d", d, j),
                     log_ch[6 * d + j], log_ch[6 * d]);
        end
      end
    end
  endtask

  task automatic start_run(input word_t ctrl);
    log_ch.delete();
    log_off.delete();
    log_data.delete();
    done_events = 0;
    build_expected();
    write_reg(REG_CTRL, ctrl);
  endtask

  task automatic test_registers();
    word_t val, rd;
    logic  err;
    apb_read(REG_STATUS, rd, err);
    check_word("prdata_o STATUS after reset", rd, 32'h0);
    check_flag("pslverr_o STATUS read", err, 1'b0);
    for (int i = 0; i < 2; i++) begin
      val = $urandom();
      write_reg(PTR_REGS[i], val);
      apb_read(PTR_REGS[i], rd, err);
      check_word($sformatf("prdata_o reg 0x%02h", PTR_REGS[i]), rd, val);
    end
    for (int i = 0; i < 9; i++) begin
      val = $urandom();
      write_reg(DIM_REGS[i], val);
      apb_read(DIM_REGS[i], rd, err);
      check_dim($sformatf("prdata_o reg 0x%02h", DIM_REGS[i]), rd[15:0], val[15:0]);
      check_dim($sformatf("prdata_o reg 0x%02h upper half", DIM_REGS[i]), rd[31:16], '0);
    end
    apb_write(8'h40, 32'hdead_beef, err);
    check_flag("pslverr_o unmapped write", err, 1'b1);
    apb_read(8'h40, rd, err);
    check_flag("pslverr_o unmapped read", err, 1'b1);
  endtask

  task automatic test_basic_walk();
    word_t status;
    logic  err;
    int    polls;
    cfg_src = 32'h0001_0000;
    cfg_dst = 32'h0002_0000;
    cfg_iw  = 16'd4;
    cfg_ih  = 16'd4;
    cfg_nc  = 16'd1;
    cfg_fw  = 16'd2;
    cfg_fh  = 16'd2;
    cfg_sw  = 16'd1;
    cfg_sh  = 16'd1;
    cfg_npw = 16'd3;
    cfg_nph = 16'd3;
    program_config();
    irq_masked = 1'b1;
    start_run(32'h1);  // interrupt stays disabled
    status = 32'h1;
    polls  = 0;
    while (status[0] && polls < POLL_LIMIT) begin
      apb_read(REG_STATUS, status, err);
      polls++;
    end
    if (status[0]) begin
      errors++;
      aborted = 1'b1;
      $display("timeout: busy still set after %0d STATUS reads in the basic walk", polls);
    end else begin
      check_flag("STATUS done", status[1], 1'b1);
      check_word("DMA done events", word_t'(done_events), word_t'(exp_src.size()));
      check_log();
    end
    irq_masked = 1'b0;
  endtask

  task automatic test_strided_run();
    word_t status;
    logic  err;
    int    cycles;
    cfg_src = 32'h0004_0100;
    cfg_dst = 32'h0008_0000;
    cfg_iw  = 16'd9;
    cfg_ih  = 16'd7;
    cfg_nc  = 16'd2;
    cfg_fw  = 16'd3;
    cfg_fh  = 16'd3;
    cfg_sw  = 16'd2;
    cfg_sh  = 16'd2;
    cfg_npw = 16'd4;
    cfg_nph = 16'd3;
    program_config();
    start_run(32'h3);
    apb_read(REG_STATUS, status, err);
    check_flag("STATUS busy after start", status[0], 1'b1);
    // once the loader is on the last descriptor the generator sits idle
    cycles = 0;
    while (log_off.size() < 6 * (exp_src.size() - 1) && cycles < IRQ_WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (log_off.size() < 6 * (exp_src.size() - 1)) begin
      errors++;
      $display("timeout: the loader did not reach the last descriptor of the strided run");
    end
    write_reg(REG_CTRL, 32'h3);  // start while busy has to be dropped
    cycles = 0;
    @(negedge clk_i);
    while (!irq_o && cycles < IRQ_WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!irq_o) begin
      errors++;
      aborted = 1'b1;
      $display("timeout: irq_o did not rise within %0d cycles of the strided run", cycles);
    end else begin
      check_word("DMA done events at irq_o", word_t'(done_events), word_t'(exp_src.size()));
      apb_read(REG_STATUS, status, err);
      check_word("prdata_o STATUS at completion", status, 32'h2);
      @(negedge clk_i);
      check_flag("irq_o after STATUS read", irq_o, 1'b0);
      // a dropped start leaves no second walk behind
      for (int i = 0; i < QUIET_CYCLES; i++) begin
        @(negedge clk_i);
        check_flag("dma_req_o after completion", dma_req_o, 1'b0);
      end
      check_log();
    end
  endtask

  initial begin
    void'($urandom(32'h44401e44));
    aborted    = 1'b0;
    irq_masked = 1'b0;
    rst_ni    <= 1'b0;
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    paddr_i   <= '0;
    pwdata_i  <= '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_registers();
    test_basic_walk();
    if (!aborted) test_strided_run();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* hdl/im2col_top.sv */
/*
 * Top level of the im2col accelerator: register file,
 * descriptor generator, descriptor FIFO and DMA loader
 */
`timescale 1ns/1ns

module im2col_top
  import im2col_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [REG_ADDR_W-1:0] paddr_i,
  input  word_t                 pwdata_i,
  output word_t                 prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  output logic                  dma_req_o,
  output word_t                 dma_addr_o,
  output word_t                 dma_wdata_o,
  input  logic                  dma_gnt_i,
  input  ch_mask_t              dma_done_i,
  output logic                  irq_o
);

  logic  start, done, push, pop, full, empty;
  word_t src_ptr, dst_ptr;
  dim_t  iw, ih, num_ch, fw, fh, stride_w, stride_h, np_w, np_h;
  word_t g_src, g_dst, g_inc1, g_inc2, g_size1, g_size2;  // generator side
  logic  g_last;
  word_t h_src, h_dst, h_inc1, h_inc2, h_size1, h_size2;  // FIFO head
  logic  h_last;

  im2col_regs u_regs (
    .clk_i, .rst_ni, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .done_i(done), .prdata_o, .pready_o, .pslverr_o, .start_o(start),
    .src_ptr_o(src_ptr), .dst_ptr_o(dst_ptr), .iw_o(iw), .ih_o(ih),
    .num_ch_o(num_ch), .fw_o(fw), .fh_o(fh), .stride_w_o(stride_w),
    .stride_h_o(stride_h), .np_w_o(np_w), .np_h_o(np_h), .irq_o
  );

  im2col_param_gen u_param_gen (
    .clk_i, .rst_ni, .start_i(start), .src_ptr_i(src_ptr), .dst_ptr_i(dst_ptr),
    .iw_i(iw), .ih_i(ih), .num_ch_i(num_ch), .fw_i(fw), .fh_i(fh),
    .stride_w_i(stride_w), .stride_h_i(stride_h), .np_w_i(np_w), .np_h_i(np_h),
    .fifo_full_i(full), .push_o(push), .desc_src_o(g_src), .desc_dst_o(g_dst),
    .desc_inc1_o(g_inc1), .desc_inc2_o(g_inc2), .desc_size1_o(g_size1),
    .desc_size2_o(g_size2), .desc_last_o(g_last)
  );

  im2col_desc_fifo u_desc_fifo (
    .clk_i, .rst_ni, .push_i(push), .pop_i(pop),
    .src_i(g_src), .dst_i(g_dst), .inc1_i(g_inc1), .inc2_i(g_inc2),
    .size1_i(g_size1), .size2_i(g_size2), .last_i(g_last),
    .src_o(h_src), .dst_o(h_dst), .inc1_o(h_inc1), .inc2_o(h_inc2),
    .size1_o(h_size1), .size2_o(h_size2), .last_o(h_last),
    .full_o(full), .empty_o(empty)
  );

  im2col_dma_loader u_dma_loader (
    .clk_i, .rst_ni, .empty_i(empty),
    .src_i(h_src), .dst_i(h_dst), .inc1_i(h_inc1), .inc2_i(h_inc2),
    .size1_i(h_size1), .size2_i(h_size2), .last_i(h_last),
    .dma_gnt_i, .dma_done_i, .pop_o(pop), .dma_req_o, .dma_addr_o,
    .dma_wdata_o, .done_o(done)
  );

endmodule

/* hdl/im2col_dma_loader.sv */
/*
 * DMA loader. Pops descriptors, picks a free DMA channel and
 * programs it with six single-word writes, then signals done
 * once the last descriptor has run and all channels are free.
 */
`timescale 1ns/1ns

module im2col_dma_loader
  import im2col_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     empty_i,
  input  word_t    src_i,
  input  word_t    dst_i,
  input  word_t    inc1_i,
  input  word_t    inc2_i,
  input  word_t    size1_i,
  input  word_t    size2_i,
  input  logic     last_i,
  input  logic     dma_gnt_i,
  input  ch_mask_t dma_done_i,
  output logic     pop_o,
  output logic     dma_req_o,
  output word_t    dma_addr_o,
  output word_t    dma_wdata_o,
  output logic     done_o
);

  load_state_e state_q, state_d;
  ch_mask_t busy_q;
  ch_idx_t  ch_q, free_ch;
  logic     free_any, wr_done;
  word_t    off;
  word_t    src_q, dst_q, inc1_q, inc2_q, size1_q, size2_q;
  logic     last_q;

  // lowest numbered idle channel wins
  always_comb begin
    free_ch = '0;
    for (int i = NUM_DMA_CH - 1; i >= 0; i--) begin
      if (!busy_q[i]) free_ch = ch_idx_t'(i);
    end
  end

  assign free_any = (busy_q != '1);
  assign pop_o    = (state_q == LD_WAIT_CH) && free_any && !empty_i;
  assign wr_done  = dma_req_o & dma_gnt_i;

  // register offset and data of the current write
  always_comb begin
    dma_req_o   = 1'b1;
    off         = '0;
    dma_wdata_o = '0;
    unique case (state_q)
      LD_WR_SRC: begin
        off         = DMA_SRC_PTR_OFF;
        dma_wdata_o = src_q;
      end
      LD_WR_DST: begin
        off         = DMA_DST_PTR_OFF;
        dma_wdata_o = dst_q;
      end
      LD_WR_INC1: begin
        off         = DMA_INC_SRC_D1_OFF;
        dma_wdata_o = inc1_q;
      end
      LD_WR_INC2: begin
        off         = DMA_INC_SRC_D2_OFF;
        dma_wdata_o = inc2_q;
      end
      LD_WR_SIZE2: begin
        off         = DMA_SIZE_D2_OFF;
        dma_wdata_o = size2_q;
      end
      LD_WR_SIZE1: begin  // this write starts the channel
        off         = DMA_SIZE_D1_OFF;
        dma_wdata_o = size1_q;
      end
      default: dma_req_o = 1'b0;
    endcase
  end

  assign dma_addr_o = DMA_BASE + word_t'(ch_q) * DMA_CH_SIZE + off;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      LD_IDLE:     if (!empty_i) state_d = LD_WAIT_CH;
      LD_WAIT_CH:  if (pop_o) state_d = LD_WR_SRC;
      LD_WR_SRC:   if (wr_done) state_d = LD_WR_DST;
      LD_WR_DST:   if (wr_done) state_d = LD_WR_INC1;
      LD_WR_INC1:  if (wr_done) state_d = LD_WR_INC2;
      LD_WR_INC2:  if (wr_done) state_d = LD_WR_SIZE2;
      LD_WR_SIZE2: if (wr_done) state_d = LD_WR_SIZE1;
      LD_WR_SIZE1: if (wr_done) state_d = last_q ? LD_DRAIN : LD_IDLE;
      LD_DRAIN:    if (busy_q == '0) state_d = LD_IDLE;
      default:     state_d = LD_IDLE;
    endcase
  end

  assign done_o = (state_q == LD_DRAIN) && (busy_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LD_IDLE;
      busy_q  <= '0;
    end else begin
      state_q <= state_d;
      for (int i = 0; i < NUM_DMA_CH; i++) begin
        if (state_q == LD_WR_SIZE1 && wr_done && ch_q == ch_idx_t'(i)) begin
          busy_q[i] <= 1'b1;
        end else if (dma_done_i[i]) begin
          busy_q[i] <= 1'b0;  // channel is free from the next cycle on
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      ch_q    <= free_ch;
      src_q   <= src_i;
      dst_q   <= dst_i;
      inc1_q  <= inc1_i;
      inc2_q  <= inc2_i;
      size1_q <= size1_i;
      size2_q <= size2_i;
      last_q  <= last_i;
    end
  end

endmodule

/* hdl/im2col_desc_fifo.sv */
/*
 * Circular descriptor FIFO between generator and DMA loader
 */
`timescale 1ns/1ns

module im2col_desc_fifo
  import im2col_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  logic  pop_i,
  input  word_t src_i,
  input  word_t dst_i,
  input  word_t inc1_i,
  input  word_t inc2_i,
  input  word_t size1_i,
  input  word_t size2_i,
  input  logic  last_i,
  output word_t src_o,
  output word_t dst_o,
  output word_t inc1_o,
  output word_t inc2_o,
  output word_t size1_o,
  output word_t size2_o,
  output logic  last_o,
  output logic  full_o,
  output logic  empty_o
);

  logic [6*$bits(word_t):0] mem_q [FIFO_DEPTH];  // six words and the last flag
  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q, rd_ptr_q;
  logic [$clog2(FIFO_DEPTH):0]   count_q;
  logic do_push, do_pop;

  assign full_o  = (count_q == FIFO_DEPTH);
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;  // pointers wrap at the depth
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + do_push - do_pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= {src_i, dst_i, inc1_i, inc2_i, size1_i, size2_i, last_i};
    end
  end

  // head entry is valid whenever the FIFO is not empty
  assign {src_o, dst_o, inc1_o, inc2_o, size1_o, size2_o, last_o} = mem_q[rd_ptr_q];

endmodule

/* hdl/im2col_param_gen.sv */
/*
 * Descriptor generator. Walks input channel, filter row and
 * filter column and forms one 2D DMA descriptor per step.
 */
`timescale 1ns/1ns

module im2col_param_gen
  import im2col_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  start_i,
  input  word_t src_ptr_i,
  input  word_t dst_ptr_i,
  input  dim_t  iw_i,
  input  dim_t  ih_i,
  input  dim_t  num_ch_i,
  input  dim_t  fw_i,
  input  dim_t  fh_i,
  input  dim_t  stride_w_i,
  input  dim_t  stride_h_i,
  input  dim_t  np_w_i,
  input  dim_t  np_h_i,
  input  logic  fifo_full_i,
  output logic  push_o,
  output word_t desc_src_o,
  output word_t desc_dst_o,
  output word_t desc_inc1_o,
  output word_t desc_inc2_o,
  output word_t desc_size1_o,
  output word_t desc_size2_o,
  output logic  desc_last_o
);

  gen_state_e state_q, state_d;
  dim_t  w_off_q, h_off_q, c_q;
  dim_t  w_nxt, h_nxt, c_nxt;
  dim_t  w_sel, h_sel, c_sel;
  logic  w_wrap, h_wrap, accept;
  word_t offs_q;     // element offset of the window origin in the input
  word_t dst_run_q;  // running output pointer
  word_t src_q, dst_q, inc2_q;
  logic  last_q;

  assign accept = (state_q == GEN_PUSH) && !fifo_full_i;

  // next loop position, the column offset is the innermost loop
  always_comb begin
    w_wrap = (w_off_q == fw_i - 16'd1);
    h_wrap = (h_off_q == fh_i - 16'd1);
    w_nxt  = w_wrap ? '0 : w_off_q + 16'd1;
    h_nxt  = h_off_q;
    c_nxt  = c_q;
    if (w_wrap) begin
      h_nxt = h_wrap ? '0 : h_off_q + 16'd1;
      if (h_wrap) begin
        c_nxt = c_q + 16'd1;
      end
    end
  end

  // ADVANCE computes the address terms of the step it moves to
  assign w_sel = (state_q == GEN_ADVANCE) ? w_nxt : w_off_q;
  assign h_sel = (state_q == GEN_ADVANCE) ? h_nxt : h_off_q;
  assign c_sel = (state_q == GEN_ADVANCE) ? c_nxt : c_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      GEN_IDLE:      if (start_i) state_d = GEN_ADDR_COMP;
      GEN_ADDR_COMP: state_d = GEN_DESC_FORM;
      GEN_DESC_FORM: state_d = GEN_PUSH;
      GEN_PUSH:      if (accept) state_d = last_q ? GEN_IDLE : GEN_ADVANCE;
      GEN_ADVANCE:   state_d = GEN_DESC_FORM;
      default:       state_d = GEN_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= GEN_IDLE;
      w_off_q <= '0;
      h_off_q <= '0;
      c_q     <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == GEN_IDLE && start_i) begin
        w_off_q <= '0;
        h_off_q <= '0;
        c_q     <= '0;
      end else if (state_q == GEN_ADVANCE) begin
        w_off_q <= w_nxt;
        h_off_q <= h_nxt;
        c_q     <= c_nxt;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == GEN_IDLE) begin
      dst_run_q <= dst_ptr_i;
    end else if (accept) begin
      dst_run_q <= dst_run_q + word_t'(np_w_i) * word_t'(np_h_i);  // one output row per step
    end
    if (state_q == GEN_ADDR_COMP || state_q == GEN_ADVANCE) begin
      offs_q <= (word_t'(c_sel) * word_t'(ih_i) + word_t'(h_sel)) * word_t'(iw_i)
                + word_t'(w_sel);
    end
    if (state_q == GEN_DESC_FORM) begin
      src_q  <= src_ptr_i + offs_q;
      dst_q  <= dst_run_q;
      // jump from the end of one patch row to the start of the next
      inc2_q <= word_t'(stride_h_i) * word_t'(iw_i)
                - (word_t'(np_w_i) - 32'd1) * word_t'(stride_w_i);
      last_q <= (c_q == num_ch_i - 16'd1) && h_wrap && w_wrap;
    end
  end

  assign push_o       = (state_q == GEN_PUSH);  // fields stay put while the FIFO is full
  assign desc_src_o   = src_q;
  assign desc_dst_o   = dst_q;
  assign desc_inc1_o  = word_t'(stride_w_i);
  assign desc_inc2_o  = inc2_q;
  assign desc_size1_o = word_t'(np_w_i);
  assign desc_size2_o = word_t'(np_h_i);
  assign desc_last_o  = last_q;

endmodule

/* hdl/im2col_regs.sv */
/*
 * APB register file of the im2col accelerator. Holds the
 * configuration, makes the start pulse and keeps the busy,
 * done and interrupt enable state.
 */
`timescale 1ns/1ns

module im2col_regs
  import im2col_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [REG_ADDR_W-1:0] paddr_i,
  input  word_t                 pwdata_i,
  input  logic                  done_i,
  output word_t                 prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  output logic                  start_o,
  output word_t                 src_ptr_o,
  output word_t                 dst_ptr_o,
  output dim_t                  iw_o,
  output dim_t                  ih_o,
  output dim_t                  num_ch_o,
  output dim_t                  fw_o,
  output dim_t                  fh_o,
  output dim_t                  stride_w_o,
  output dim_t                  stride_h_o,
  output dim_t                  np_w_o,
  output dim_t                  np_h_o,
  output logic                  irq_o
);

  logic wr_en, rd_en, hit;
  logic start_q, busy_q, done_q, irq_en_q;

  assign wr_en = psel_i & penable_i & pwrite_i;  // write takes effect at the access edge
  assign rd_en = psel_i & penable_i & ~pwrite_i;

  // read mux, also flags an unmapped address
  always_comb begin
    hit      = 1'b1;
    prdata_o = '0;
    case (paddr_i)
      REG_CTRL:     prdata_o = {30'd0, irq_en_q, 1'b0};
      REG_STATUS:   prdata_o = {30'd0, done_q, busy_q};
      REG_SRC_PTR:  prdata_o = src_ptr_o;
      REG_DST_PTR:  prdata_o = dst_ptr_o;
      REG_IW:       prdata_o = word_t'(iw_o);
      REG_IH:       prdata_o = word_t'(ih_o);
      REG_NUM_CH:   prdata_o = word_t'(num_ch_o);
      REG_FW:       prdata_o = word_t'(fw_o);
      REG_FH:       prdata_o = word_t'(fh_o);
      REG_STRIDE_W: prdata_o = word_t'(stride_w_o);
      REG_STRIDE_H: prdata_o = word_t'(stride_h_o);
      REG_NP_W:     prdata_o = word_t'(np_w_o);
      REG_NP_H:     prdata_o = word_t'(np_h_o);
      default:      hit = 1'b0;
    endcase
  end

  assign pready_o  = 1'b1;                          // no wait states
  assign pslverr_o = psel_i & penable_i & ~hit;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_en_q   <= 1'b0;
      src_ptr_o  <= '0;
      dst_ptr_o  <= '0;
      iw_o       <= '0;
      ih_o       <= '0;
      num_ch_o   <= '0;
      fw_o       <= '0;
      fh_o       <= '0;
      stride_w_o <= '0;
      stride_h_o <= '0;
      np_w_o     <= '0;
      np_h_o     <= '0;
    end else if (wr_en) begin
      case (paddr_i)
        REG_CTRL:     irq_en_q   <= pwdata_i[1];
        REG_SRC_PTR:  src_ptr_o  <= pwdata_i;
        REG_DST_PTR:  dst_ptr_o  <= pwdata_i;
        REG_IW:       iw_o       <= pwdata_i[15:0];
        REG_IH:       ih_o       <= pwdata_i[15:0];
        REG_NUM_CH:   num_ch_o   <= pwdata_i[15:0];
        REG_FW:       fw_o       <= pwdata_i[15:0];
        REG_FH:       fh_o       <= pwdata_i[15:0];
        REG_STRIDE_W: stride_w_o <= pwdata_i[15:0];
        REG_STRIDE_H: stride_h_o <= pwdata_i[15:0];
        REG_NP_W:     np_w_o     <= pwdata_i[15:0];
        REG_NP_H:     np_h_o     <= pwdata_i[15:0];
        default:      ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      // a start request while a run is in progress is dropped
      start_q <= wr_en && (paddr_i == REG_CTRL) && pwdata_i[0] && !busy_q && !start_q;
      if (start_q) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
      if (done_i) begin
        done_q <= 1'b1;
      end else if (rd_en && (paddr_i == REG_STATUS)) begin
        done_q <= 1'b0;                             // read to clear
      end
    end
  end

  assign start_o = start_q;
  assign irq_o   = done_q & irq_en_q;

endmodule

/* hdl/im2col_pkg.sv */
/*
 * Shared definitions of the im2col accelerator: data widths,
 * APB register map, DMA register offsets, FIFO depth, DMA
 * channel count and the state encodings of both FSMs.
 */
package im2col_pkg;

  typedef logic [31:0] word_t;    // pointer, increment or bus word
  typedef logic [15:0] dim_t;     // dimension, stride or patch count
  typedef logic        ch_idx_t;  // DMA channel index
  typedef logic [1:0]  ch_mask_t; // one busy bit per DMA channel

  localparam int unsigned REG_ADDR_W = 8;

  // APB register offsets
  localparam logic [REG_ADDR_W-1:0] REG_CTRL     = 8'h00;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS   = 8'h04;
  localparam logic [REG_ADDR_W-1:0] REG_SRC_PTR  = 8'h08;
  localparam logic [REG_ADDR_W-1:0] REG_DST_PTR  = 8'h0C;
  localparam logic [REG_ADDR_W-1:0] REG_IW       = 8'h10;
  localparam logic [REG_ADDR_W-1:0] REG_IH       = 8'h14;
  localparam logic [REG_ADDR_W-1:0] REG_NUM_CH   = 8'h18;
  localparam logic [REG_ADDR_W-1:0] REG_FW       = 8'h1C;
  localparam logic [REG_ADDR_W-1:0] REG_FH       = 8'h20;
  localparam logic [REG_ADDR_W-1:0] REG_STRIDE_W = 8'h24;
  localparam logic [REG_ADDR_W-1:0] REG_STRIDE_H = 8'h28;
  localparam logic [REG_ADDR_W-1:0] REG_NP_W     = 8'h2C;
  localparam logic [REG_ADDR_W-1:0] REG_NP_H     = 8'h30;

  // DMA address map, each channel owns a DMA_CH_SIZE window
  localparam word_t DMA_BASE           = 32'h0000_3000;
  localparam word_t DMA_CH_SIZE        = 32'h0000_0100;
  localparam word_t DMA_SRC_PTR_OFF    = 32'h00;
  localparam word_t DMA_DST_PTR_OFF    = 32'h04;
  localparam word_t DMA_SIZE_D1_OFF    = 32'h0C;
  localparam word_t DMA_SIZE_D2_OFF    = 32'h10;
  localparam word_t DMA_INC_SRC_D1_OFF = 32'h18;
  localparam word_t DMA_INC_SRC_D2_OFF = 32'h1C;

  localparam int unsigned NUM_DMA_CH = 2;
  localparam int unsigned FIFO_DEPTH = 4;

  typedef enum logic [2:0] {
    GEN_IDLE,
    GEN_ADDR_COMP,
    GEN_DESC_FORM,
    GEN_PUSH,
    GEN_ADVANCE
  } gen_state_e;

  typedef enum logic [3:0] {
    LD_IDLE,
    LD_WAIT_CH,
    LD_WR_SRC,
    LD_WR_DST,
    LD_WR_INC1,
    LD_WR_INC2,
    LD_WR_SIZE2,
    LD_WR_SIZE1,
    LD_DRAIN
  } load_state_e;

endpackage
